// ==== Bender.yml ====
package:
  name: pocket_core_ctrl

sources:
  - logic/pocket_core_pkg.sv
  - logic/bridge_settings_regs.sv
  - logic/pll_reconfig_seq.sv
  - logic/core_reset_ctrl.sv
  - logic/video_slot_stage.sv
  - logic/pocket_core_ctrl_top.sv
  - target: simulation
    files:
      - verif/pocket_core_ctrl_tb.sv

// ==== all.f ====
logic/pocket_core_pkg.sv
logic/bridge_settings_regs.sv
logic/pll_reconfig_seq.sv
logic/core_reset_ctrl.sv
logic/video_slot_stage.sv
logic/pocket_core_ctrl_top.sv
verif/pocket_core_ctrl_tb.sv

// ==== logic/bridge_settings_regs.sv ====
//////////////////////////////////////////////////////////////////////
// bridge settings registers
// decodes host bridge writes into the core settings block
// and a one cycle reset command pulse
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module bridge_settings_regs (
  input  logic                           clk_74a,
  input  logic                           pll_core_locked,
  input  logic                           bridge_wr,
  input  pocket_core_pkg::bridge_addr_t  bridge_addr,
  input  pocket_core_pkg::bridge_data_t  bridge_wr_data,
  output pocket_core_pkg::core_settings_t settings,
  output logic                           reset_cmd
);

  //////////////////////////////////////////////////////////////////////
  // settings block
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings <= '0;
    end else if (bridge_wr) begin
      // only the low bits of the data word are meaningful
      case (bridge_addr)
        pocket_core_pkg::addr_download: begin
          settings.ioctl_download <= bridge_wr_data[0];
        end
        pocket_core_pkg::addr_rom_size: begin
          settings.rom_size <= bridge_wr_data[3:0];
        end
        pocket_core_pkg::addr_rom_type: begin
          settings.rom_type <= bridge_wr_data[7:0];
        end
        pocket_core_pkg::addr_ram_size: begin
          settings.ram_size <= bridge_wr_data[3:0];
        end
        pocket_core_pkg::addr_pal: begin
          // a change here kicks off the video standard switch
          settings.pal <= bridge_wr_data[0];
        end
        pocket_core_pkg::addr_multitap: begin
          settings.multitap_enabled <= bridge_wr_data[0];
        end
        pocket_core_pkg::addr_lightgun: begin
          // bit 0 enable, bit 1 gun type
          settings.lightgun_enabled <= bridge_wr_data[0];
          settings.lightgun_type    <= bridge_wr_data[1];
        end
        pocket_core_pkg::addr_aim_speed: begin
          settings.lightgun_aim_speed <= bridge_wr_data[7:0];
        end
        pocket_core_pkg::addr_video_43: begin
          settings.use_4_3_video <= bridge_wr_data[0];
        end
        default: begin
          // unmapped, ignore
          settings <= settings;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reset command
  //////////////////////////////////////////////////////////////////////

  // data word is don't care, the address alone is the command
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_cmd <= 1'b0;
    end else begin
      reset_cmd <= bridge_wr && (bridge_addr == pocket_core_pkg::addr_reset);
    end
  end

endmodule

// ==== logic/core_reset_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// core reset controller
// host reset hold counter and the registered core reset level
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module core_reset_ctrl (
  input  logic clk_74a,
  input  logic pll_core_locked,
  input  logic reset_cmd,
  input  logic transitioning,
  output logic core_reset
);

  // remaining hold cycles
  pocket_core_pkg::reset_cnt_t hold_cnt;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_cnt <= '0;
    end else if (reset_cmd) begin
      // a new command restarts the full hold
      hold_cnt <= pocket_core_pkg::reset_cnt_t'(pocket_core_pkg::reset_hold_cycles);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // held while counting or while the video standard switches
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      core_reset <= 1'b0;
    end else begin
      core_reset <= (hold_cnt != '0) || transitioning;
    end
  end

endmodule

// ==== logic/pll_reconfig_seq.sv ====
//////////////////////////////////////////////////////////////////////
// video standard switch sequencer
// on a PAL flag change, writes the clock synthesizer management
// port, waits for the reconfig to finish, then pulses its reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pll_reconfig_seq (
  input  logic                       clk_74a,
  input  logic                       pll_core_locked,
  input  logic                       pal,
  input  logic                       cfg_waitrequest,
  output logic                       cfg_write,
  output pocket_core_pkg::cfg_addr_t cfg_address,
  output logic                       pll_reset,
  output logic                       transitioning
);

  // PAL staging pair, edge seen as a difference between the two
  logic pal_d1;
  logic pal_d2;

  // step counter, idle at zero
  pocket_core_pkg::seq_state_t step;

  //////////////////////////////////////////////////////////////////////
  // step counter and management writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      pal_d1      <= 1'b0;
      pal_d2      <= 1'b0;
      step        <= '0;
      cfg_write   <= 1'b0;
      cfg_address <= '0;
      pll_reset   <= 1'b0;
    end else begin
      pal_d1 <= pal;
      pal_d2 <= pal_d1;

      // write strobe is a single cycle
      cfg_write <= 1'b0;

      // free running once started
      // a PAL change mid sequence does not restart it
      if (step != '0) begin
        step <= step + 1'b1;
      end else if (pal_d1 != pal_d2) begin
        step <= pocket_core_pkg::pll_step_mode;
      end

      case (step)
        pocket_core_pkg::pll_step_mode: begin
          // mode register, waitrequest mode
          cfg_address <= pocket_core_pkg::cfg_addr_mode;
          cfg_write   <= 1'b1;
        end
        pocket_core_pkg::pll_step_mif: begin
          // select the stored profile
          cfg_address <= pocket_core_pkg::cfg_addr_mif;
          cfg_write   <= 1'b1;
        end
        pocket_core_pkg::pll_step_start: begin
          // kick the reconfig
          cfg_address <= pocket_core_pkg::cfg_addr_start;
          cfg_write   <= 1'b1;
        end
        pocket_core_pkg::pll_step_wait: begin
          // park here until the synthesizer drops waitrequest
          if (cfg_waitrequest) begin
            step <= pocket_core_pkg::pll_step_wait;
          end else begin
            step <= pocket_core_pkg::pll_step_rst_start;
          end
        end
        pocket_core_pkg::pll_step_rst_start: begin
          pll_reset <= 1'b1;
        end
        pocket_core_pkg::pll_step_rst_end: begin
          // 20 cycles of reset, back to idle
          pll_reset <= 1'b0;
          step      <= '0;
        end
        default: begin
          // gap steps between writes
          cfg_address <= cfg_address;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // switch in progress
  //////////////////////////////////////////////////////////////////////

  // also covers a write or busy synthesizer outside the step window
  assign transitioning = (step != '0) || cfg_waitrequest || cfg_write;

endmodule

// ==== logic/pocket_core_ctrl_top.sv ====
//////////////////////////////////////////////////////////////////////
// pocket core control plane top level
// settings decoder, video standard switch with core reset,
// and the video slot output stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pocket_core_ctrl_top (
  input  logic                           clk_74a,
  input  logic                           pll_core_locked,
  input  logic                           bridge_wr,
  input  pocket_core_pkg::bridge_addr_t  bridge_addr,
  input  pocket_core_pkg::bridge_data_t  bridge_wr_data,
  input  logic                           cfg_waitrequest,
  input  pocket_core_pkg::pixel_t        pixel,
  input  pocket_core_pkg::snap_index_t   snap_index,
  output pocket_core_pkg::core_settings_t settings,
  output logic                           cfg_write,
  output pocket_core_pkg::cfg_addr_t     cfg_address,
  output logic                           pll_reset,
  output logic                           core_reset,
  output logic                           video_de,
  output pocket_core_pkg::video_word_u   video_rgb
);

  // host reset request, one cycle
  logic reset_cmd;
  // video standard switch running
  logic transitioning;

  //////////////////////////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////////////////////////

  bridge_settings_regs bridge_settings_regs_i (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_wr      (bridge_wr),
    .bridge_addr    (bridge_addr),
    .bridge_wr_data (bridge_wr_data),
    .settings       (settings),
    .reset_cmd      (reset_cmd)
  );

  //////////////////////////////////////////////////////////////////////
  // switch sequencer and core reset
  //////////////////////////////////////////////////////////////////////

  pll_reconfig_seq pll_reconfig_seq_i (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .pal            (settings.pal),
    .cfg_waitrequest(cfg_waitrequest),
    .cfg_write      (cfg_write),
    .cfg_address    (cfg_address),
    .pll_reset      (pll_reset),
    .transitioning  (transitioning)
  );

  core_reset_ctrl core_reset_ctrl_i (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .reset_cmd      (reset_cmd),
    .transitioning  (transitioning),
    .core_reset     (core_reset)
  );

  //////////////////////////////////////////////////////////////////////
  // output side
  //////////////////////////////////////////////////////////////////////

  video_slot_stage video_slot_stage_i (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .pixel          (pixel),
    .snap_index     (snap_index),
    .use_4_3_video  (settings.use_4_3_video),
    .video_de       (video_de),
    .video_rgb      (video_rgb)
  );

endmodule

// ==== logic/pocket_core_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// pocket core control plane shared definitions
// bridge register map, reset hold, synthesizer reconfig steps
// and the settings, pixel and video word types
//////////////////////////////////////////////////////////////////////

package pocket_core_pkg;

  // bridge bus words
  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  // settings register map
  localparam bridge_addr_t addr_download  = 32'h0000_0000;
  localparam bridge_addr_t addr_rom_size  = 32'h0000_0004;
  localparam bridge_addr_t addr_rom_type  = 32'h0000_0008;
  localparam bridge_addr_t addr_ram_size  = 32'h0000_000C;
  localparam bridge_addr_t addr_pal       = 32'h0000_0010;
  localparam bridge_addr_t addr_reset     = 32'h0000_0050;
  localparam bridge_addr_t addr_multitap  = 32'h0000_0100;
  localparam bridge_addr_t addr_lightgun  = 32'h0000_0104;
  localparam bridge_addr_t addr_aim_speed = 32'h0000_0108;
  localparam bridge_addr_t addr_video_43  = 32'h0000_0200;

  // core reset hold, in clk_74a cycles
  localparam int unsigned reset_hold_cycles = 64;
  typedef logic [6:0] reset_cnt_t;

  // synthesizer management port
  typedef logic [5:0] cfg_addr_t;
  localparam cfg_addr_t cfg_addr_mode  = 6'd0;
  localparam cfg_addr_t cfg_addr_start = 6'd2;
  localparam cfg_addr_t cfg_addr_mif   = 6'd31;

  // reconfig step counter, 0 is idle
  typedef logic [7:0] seq_state_t;
  localparam seq_state_t pll_step_mode      = 8'd1;
  localparam seq_state_t pll_step_mif       = 8'd3;
  localparam seq_state_t pll_step_start     = 8'd5;
  localparam seq_state_t pll_step_wait      = 8'd7;
  localparam seq_state_t pll_step_rst_start = 8'd8;
  localparam seq_state_t pll_step_rst_end   = 8'd28;

  // host visible core settings
  typedef struct packed {
    logic       ioctl_download;
    logic [7:0] rom_type;
    logic [3:0] rom_size;
    logic [3:0] ram_size;
    logic       pal;
    logic       multitap_enabled;
    logic       lightgun_enabled;
    logic       lightgun_type;
    logic [7:0] lightgun_aim_speed;
    logic       use_4_3_video;
  } core_settings_t;

  // video stream
  typedef logic [23:0] rgb_t;
  typedef logic [7:0] snap_index_t;

  typedef struct packed {
    logic de;
    logic vs;
    rgb_t rgb;
  } pixel_t;

  // end of line slot word layout
  typedef struct packed {
    logic [8:0]  pad_hi;
    logic        field_odd;
    logic        wide_43;
    logic [12:0] pad_lo;
  } video_slot_t;

  // colour while de is high, slot word right after the line
  typedef union packed {
    rgb_t        rgb;
    video_slot_t slot;
  } video_word_u;

endpackage

// ==== logic/video_slot_stage.sv ====
//////////////////////////////////////////////////////////////////////
// video output stage
// one cycle pixel register, inserts the end of line slot word
// carrying the field bit and the 4:3 flag
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module video_slot_stage (
  input  logic                         clk_74a,
  input  logic                         pll_core_locked,
  input  pocket_core_pkg::pixel_t      pixel,
  input  pocket_core_pkg::snap_index_t snap_index,
  input  logic                         use_4_3_video,
  output logic                         video_de,
  output pocket_core_pkg::video_word_u video_rgb
);

  // previous de and vs for edge detect
  logic prev_de;
  logic prev_vs;

  // snap index captured at frame start
  pocket_core_pkg::snap_index_t latched_snap;

  // slot word built from the latched field
  pocket_core_pkg::video_slot_t slot_word;

  //////////////////////////////////////////////////////////////////////
  // edge tracking
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      prev_de  <= 1'b0;
      prev_vs  <= 1'b0;
      video_de <= 1'b0;
    end else begin
      prev_de  <= pixel.de;
      prev_vs  <= pixel.vs;
      // de simply delayed by one
      video_de <= pixel.de;
    end
  end

  // vs rising edge
  always_ff @(posedge clk_74a) begin
    if (pixel.vs && !prev_vs) begin
      latched_snap <= snap_index;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output word
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    slot_word           = '0;
    // odd field when the snap index is even
    slot_word.field_odd = ~latched_snap[0];
    slot_word.wide_43   = use_4_3_video;
  end

  always_ff @(posedge clk_74a) begin
    if (pixel.de) begin
      video_rgb.rgb <= pixel.rgb;
    end else if (prev_de) begin
      // first blank cycle after the last pixel
      video_rgb.slot <= slot_word;
    end
  end

endmodule

// ==== verif/pocket_core_ctrl_tb.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the pocket core control plane
// table driven settings writes, host reset hold, video standard
// switch against a synthesizer model, end of line slot words
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pocket_core_ctrl_tb;

  // one bridge write and the whole settings word expected after it
  typedef struct packed {
    pocket_core_pkg::bridge_addr_t   addr;
    pocket_core_pkg::bridge_data_t   data;
    pocket_core_pkg::core_settings_t expect_settings;
  } write_row_t;

  logic                            clk_74a = 1'b0;
  logic                            pll_core_locked;
  logic                            bridge_wr;
  pocket_core_pkg::bridge_addr_t   bridge_addr;
  pocket_core_pkg::bridge_data_t   bridge_wr_data;
  logic                            cfg_waitrequest;
  pocket_core_pkg::pixel_t         pixel;
  pocket_core_pkg::snap_index_t    snap_index;
  pocket_core_pkg::core_settings_t settings;
  logic                            cfg_write;
  pocket_core_pkg::cfg_addr_t      cfg_address;
  logic                            pll_reset;
  logic                            core_reset;
  logic                            video_de;
  pocket_core_pkg::video_word_u    video_rgb;

  write_row_t rows [10];
  logic [5:0] want_addr [3];
  logic [7:0] snap;
  int errors = 0;
  int timeouts = 0;
  int pulses;
  int cycle;
  int last_pulse;
  int high_cycles;
  int extra;
  int t;

  // synthesizer model state
  int   wr_seen = 0;
  int   busy_left = 0;
  logic start_busy = 1'b0;

  always #20 clk_74a = ~clk_74a;

  pocket_core_ctrl_top pocket_core_ctrl_top_i (.*);

  //////////////////////////////////////////////////////////////////////
  // synthesizer management model
  //////////////////////////////////////////////////////////////////////

  // third write is the reconfig start
  always @(negedge clk_74a) begin
    if (cfg_write === 1'b1) begin
      wr_seen = wr_seen + 1;
      if (wr_seen == 3) begin
        wr_seen    = 0;
        start_busy = 1'b1;
      end
    end
  end

  // busy for a random 5 to 20 cycles
  always @(posedge clk_74a) begin
    if (start_busy) begin
      start_busy = 1'b0;
      busy_left  = 5 + ($urandom % 16);
      cfg_waitrequest <= 1'b1;
    end else if (busy_left > 0) begin
      busy_left = busy_left - 1;
      if (busy_left == 0) cfg_waitrequest <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    errors++;
    $display("[FAIL] %s got %h expected %h", name, got, want);
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timed out waiting for %s", what);
  endtask

  // single cycle strobe that returns at the negedge after it was taken
  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    bridge_wr      <= 1'b1;
    bridge_addr    <= addr;
    bridge_wr_data <= data;
    @(posedge clk_74a);
    bridge_wr <= 1'b0;
    @(negedge clk_74a);
  endtask

  // vs pulse, eight random pixels, then the slot word check
  task automatic send_line(input logic [7:0] snap_val, input logic wide);
    logic [23:0] sent [$];
    logic [23:0] colour;
    logic [23:0] want;
    logic [23:0] slot_want;
    @(posedge clk_74a);
    pixel      <= '{de: 1'b0, vs: 1'b1, rgb: 24'h0};
    snap_index <= snap_val;
    @(posedge clk_74a);
    pixel.vs <= 1'b0;
    // index moves on after the vs rise so only the latched value is right
    snap_index <= snap_val ^ 8'h01;
    for (int i = 0; i <= 8; i++) begin
      @(posedge clk_74a);
      if (i < 8) begin
        colour = 24'($urandom);
        pixel <= '{de: 1'b1, vs: 1'b0, rgb: colour};
        sent.push_back(colour);
      end else begin
        pixel.de <= 1'b0;
      end
      @(negedge clk_74a);
      // output lags the input by one edge
      if (i > 0) begin
        want = sent.pop_front();
        if (video_de !== 1'b1) report_mismatch("video_de", video_de, 1);
        if (video_rgb.rgb !== want) report_mismatch("video_rgb", video_rgb.rgb, want);
      end
    end
    @(negedge clk_74a);
    // zero pads and field odd on an even snap index
    slot_want = {9'h0, ~snap_val[0], wide, 13'h0};
    if (video_de !== 1'b0) report_mismatch("video_de", video_de, 0);
    if (video_rgb !== slot_want) report_mismatch("video_rgb slot", video_rgb, slot_want);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hed90a7c4));
    pll_core_locked = 1'b0;
    bridge_wr       = 1'b0;
    bridge_addr     = '0;
    bridge_wr_data  = '0;
    cfg_waitrequest = 1'b0;
    pixel           = '0;
    snap_index      = '0;
    // cumulative settings after each write
    // the unmapped 0x300 write changes nothing
    rows[0] = '{pocket_core_pkg::addr_download,  32'h0000_0001, 30'h2000_0000};
    rows[1] = '{pocket_core_pkg::addr_rom_type,  32'h0000_00a5, 30'h34a0_0000};
    rows[2] = '{pocket_core_pkg::addr_rom_size,  32'h0000_003c, 30'h34b8_0000};
    rows[3] = '{pocket_core_pkg::addr_ram_size,  32'h0000_0007, 30'h34b8_e000};
    rows[4] = '{pocket_core_pkg::addr_multitap,  32'h0000_0001, 30'h34b8_e800};
    rows[5] = '{pocket_core_pkg::addr_lightgun,  32'h0000_0002, 30'h34b8_ea00};
    rows[6] = '{pocket_core_pkg::addr_aim_speed, 32'h0000_01f4, 30'h34b8_ebe8};
    rows[7] = '{pocket_core_pkg::addr_video_43,  32'h0000_0001, 30'h34b8_ebe9};
    rows[8] = '{32'h0000_0300,                   32'h0000_00ff, 30'h34b8_ebe9};
    rows[9] = '{pocket_core_pkg::addr_download,  32'h0000_0000, 30'h14b8_ebe9};
    want_addr[0] = 6'd0;
    want_addr[1] = 6'd31;
    want_addr[2] = 6'd2;

    repeat (3) @(posedge clk_74a);
    pll_core_locked <= 1'b1;
    @(negedge clk_74a);
    if (settings !== '0) report_mismatch("settings", settings, 0);
    if (core_reset !== 1'b0) report_mismatch("core_reset", core_reset, 0);
    if (pll_reset !== 1'b0) report_mismatch("pll_reset", pll_reset, 0);

    foreach (rows[i]) begin
      bridge_write(rows[i].addr, rows[i].data);
      if (settings !== rows[i].expect_settings) begin
        report_mismatch("settings", settings, rows[i].expect_settings);
      end
    end

    // host reset hold
    bridge_write(pocket_core_pkg::addr_reset, 32'h1);
    t = 0;
    while (core_reset !== 1'b1 && t < 10) begin
      @(negedge clk_74a);
      t++;
    end
    if (t >= 10) report_timeout("core_reset to rise after the reset command");
    high_cycles = 0;
    while (core_reset === 1'b1 && high_cycles < 200) begin
      high_cycles++;
      @(negedge clk_74a);
    end
    if (high_cycles != pocket_core_pkg::reset_hold_cycles) begin
      report_mismatch("core_reset high cycles", high_cycles,
                      pocket_core_pkg::reset_hold_cycles);
    end

    // video standard switch with its three management writes
    bridge_write(pocket_core_pkg::addr_pal, 32'h1);
    pulses     = 0;
    cycle      = 0;
    last_pulse = 0;
    while (pulses < 3 && cycle < 40) begin
      if (cfg_write === 1'b1) begin
        if (cfg_address !== want_addr[pulses]) begin
          report_mismatch("cfg_address", cfg_address, want_addr[pulses]);
        end
        if (pulses > 0 && cycle - last_pulse != 2) begin
          report_mismatch("cfg_write spacing", cycle - last_pulse, 2);
        end
        if (core_reset !== 1'b1) report_mismatch("core_reset", core_reset, 1);
        last_pulse = cycle;
        pulses++;
      end
      @(negedge clk_74a);
      cycle++;
    end
    if (pulses < 3) report_timeout("three cfg_write pulses");

    // synthesizer busy and then its reset pulse
    t     = 0;
    extra = 0;
    while (pll_reset !== 1'b1 && t < 60) begin
      if (cfg_write === 1'b1) extra++;
      if (core_reset !== 1'b1) report_mismatch("core_reset", core_reset, 1);
      @(negedge clk_74a);
      t++;
    end
    if (t >= 60) report_timeout("pll_reset to rise");
    if (cfg_waitrequest !== 1'b0) report_mismatch("cfg_waitrequest", cfg_waitrequest, 0);
    high_cycles = 0;
    while (pll_reset === 1'b1 && high_cycles < 100) begin
      if (cfg_write === 1'b1) extra++;
      if (core_reset !== 1'b1) report_mismatch("core_reset", core_reset, 1);
      high_cycles++;
      @(negedge clk_74a);
    end
    if (high_cycles != 20) report_mismatch("pll_reset high cycles", high_cycles, 20);
    if (extra != 0) report_mismatch("extra cfg_write pulses", extra, 0);
    t = 0;
    while (core_reset !== 1'b0 && t < 10) begin
      @(negedge clk_74a);
      t++;
    end
    if (t >= 10) report_timeout("core_reset to fall after the switch");

    // slot words for both 4:3 values and both snap parities
    for (int w = 0; w < 2; w++) begin
      bridge_write(pocket_core_pkg::addr_video_43, w);
      for (int p = 0; p < 2; p++) begin
        snap = (8'($urandom) & 8'hfe) | 8'(p);
        send_line(snap, w[0]);
      end
    end

    $display("mismatches %0d timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
